// File: mem_bus_pkg.sv
`default_nettype none

////////////////////////////////////////
// Off-chip and requester bus widths
////////////////////////////////////////
package mem_bus_pkg;

  // Data word, one 16-bit machine word
  localparam int WORD_W = 16;

  // Word address, not byte address
  localparam int ADDR_W = 16;

  // One data word on any bus
  typedef logic [WORD_W-1:0] word_t;

  // One word address on any bus
  typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

////////////////////////////////////////
// Cache geometry
////////////////////////////////////////
package cache_pkg;

  localparam int LINE_WORDS_DEF = 4;   // Words per line
  localparam int NUM_SETS_DEF   = 32;  // Direct mapped, one line per set

  // Bits needed to count up to value, value a power of two
  function automatic int log2(input int value);
    int width;
    width = 0;
    while ((1 << width) < value) begin
      width++;
    end
    return width;
  endfunction

  // Tag is what is left of the word address after index and offset
  function automatic int tag_w(input int line_words, input int num_sets);
    int used;
    used = log2(line_words) + log2(num_sets);  // Offset plus index
    return mem_bus_pkg::ADDR_W - used;
  endfunction

endpackage

`default_nettype wire

// File: mem_port_if.sv
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////
// Cache to arbiter request port
////////////////////////////////////////
interface mem_port_if;

  // Client side requests
  logic               req;    // Client wants the off-chip bus
  logic               wr;     // Request is a one-cycle write
  mem_bus_pkg::addr_t addr;   // Word address of the access
  mem_bus_pkg::word_t wdata;  // Store data, write-through

  // Arbiter side answers
  logic               grant;  // Bus is ours this cycle
  logic               valid;  // Read word is on rdata
  mem_bus_pkg::word_t rdata;  // Read word, only for the granted client

  // A cache drives the request
  modport client (
    output req, wr, addr, wdata,
    input  grant, valid, rdata
  );

  // The arbiter drives the answer
  modport server (
    input  req, wr, addr, wdata,
    output grant, valid, rdata
  );

endinterface

`default_nettype wire

// File: cache_array.sv
`timescale 1ns/100ps
`default_nettype none

module cache_array #(
  parameter int LINE_WORDS = cache_pkg::LINE_WORDS_DEF,
  parameter int NUM_SETS   = cache_pkg::NUM_SETS_DEF
) (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  mem_bus_pkg::addr_t                   addr,         // Lookup and fill address
  input  logic                                 fill_we,      // Refill word arrives
  input  mem_bus_pkg::word_t                   fill_word,
  input  logic [cache_pkg::log2(LINE_WORDS)-1:0] fill_offset,  // Word slot within the line
  input  logic                                 fill_done,    // Last word, line is complete
  input  logic                                 store_we,     // Write hit update
  input  mem_bus_pkg::word_t                   store_data,
  output logic                                 hit,
  output mem_bus_pkg::word_t                   rdata
);

  localparam int OFF_W = cache_pkg::log2(LINE_WORDS);
  localparam int IDX_W = cache_pkg::log2(NUM_SETS);
  localparam int TAG_W = cache_pkg::tag_w(LINE_WORDS, NUM_SETS);

  logic [TAG_W-1:0]   tag_mem  [NUM_SETS];               // One tag per set
  mem_bus_pkg::word_t data_mem [NUM_SETS][LINE_WORDS];   // Line storage
  logic [NUM_SETS-1:0] valid_q;                          // Line present

  logic [TAG_W-1:0] addr_tag;
  logic [IDX_W-1:0] addr_idx;
  logic [OFF_W-1:0] addr_off;

  ////////////////////////////////////////
  // Address split and lookup
  ////////////////////////////////////////
  assign addr_off = addr[OFF_W-1:0];
  assign addr_idx = addr[OFF_W +: IDX_W];
  assign addr_tag = addr[mem_bus_pkg::ADDR_W-1 -: TAG_W];

  assign hit   = valid_q[addr_idx] && (tag_mem[addr_idx] == addr_tag);  // Same cycle as addr
  assign rdata = data_mem[addr_idx][addr_off];

  ////////////////////////////////////////
  // Valid bits, only control state here
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (fill_done) begin
      valid_q[addr_idx] <= 1'b1;                 // Whole line now in
    end else if (fill_we) begin
      valid_q[addr_idx] <= 1'b0;                 // Old line partly overwritten
    end
  end

  // Tag lands with the last word
  always_ff @(posedge clk) begin
    if (fill_done) begin
      tag_mem[addr_idx] <= addr_tag;
    end
  end

  // Data words, from refill or from a store
  always_ff @(posedge clk) begin
    if (fill_we) begin
      data_mem[addr_idx][fill_offset] <= fill_word;
    end else if (store_we) begin
      data_mem[addr_idx][addr_off] <= store_data;
    end
  end

  // Refill and store come from different controller states
  a_fill_store_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(fill_we && store_we));

endmodule

`default_nettype wire

// File: icache.sv
`timescale 1ns/100ps
`default_nettype none

module icache #(
  parameter int LINE_WORDS = cache_pkg::LINE_WORDS_DEF,
  parameter int NUM_SETS   = cache_pkg::NUM_SETS_DEF
) (
  input  logic               clk,
  input  logic               arst_n,
  input  mem_bus_pkg::addr_t addr,   // Fetch address, held until hit
  output mem_bus_pkg::word_t data,   // Instruction word
  output logic               hit,    // Low stalls the fetch
  mem_port_if.client         port
);

  localparam int OFF_W = cache_pkg::log2(LINE_WORDS);

  localparam logic ST_IDLE = 1'b0;  // Lookup only
  localparam logic ST_FILL = 1'b1;  // Line refill in progress

  logic             state;
  logic [OFF_W-1:0] fill_cnt;   // Next word of the line to read
  logic             arr_hit;
  logic             fill_we;
  logic             fill_done;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  cache_array #(
    .LINE_WORDS (LINE_WORDS),
    .NUM_SETS   (NUM_SETS)
  ) array_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .addr        (addr),
    .fill_we     (fill_we),
    .fill_word   (port.rdata),
    .fill_offset (fill_cnt),
    .fill_done   (fill_done),
    .store_we    (1'b0),        // Read only cache
    .store_data  ('0),
    .hit         (arr_hit),
    .rdata       (data)
  );

  assign fill_we   = (state == ST_FILL) && port.valid;  // valid only when granted
  assign fill_done = fill_we && (&fill_cnt);           // Last slot of the line
  assign hit       = (state == ST_IDLE) && arr_hit;

  // Read requests walk the line from offset 0
  assign port.req   = (state == ST_FILL);
  assign port.wr    = 1'b0;
  assign port.addr  = {addr[mem_bus_pkg::ADDR_W-1:OFF_W], fill_cnt};
  assign port.wdata = '0;

  ////////////////////////////////////////
  // Miss FSM
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      fill_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: if (!arr_hit) begin
          state    <= ST_FILL;   // Start refill next cycle
          fill_cnt <= '0;
        end
        ST_FILL: if (port.valid) begin
          fill_cnt <= fill_cnt + 1'b1;
          if (fill_done) state <= ST_IDLE;  // req drops, hit next cycle
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: dcache.sv
`timescale 1ns/100ps
`default_nettype none

module dcache #(
  parameter int LINE_WORDS = cache_pkg::LINE_WORDS_DEF,
  parameter int NUM_SETS   = cache_pkg::NUM_SETS_DEF
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               en,      // Load or store present
  input  logic               wr,      // Store
  input  mem_bus_pkg::addr_t addr,
  input  mem_bus_pkg::word_t wdata,
  output mem_bus_pkg::word_t rdata,
  output logic               hit,     // Access done this cycle
  mem_port_if.client         port
);

  localparam int OFF_W = cache_pkg::log2(LINE_WORDS);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_FILL = 1'b1;

  logic             state;
  logic [OFF_W-1:0] fill_cnt;
  logic             arr_hit;
  logic             fill_we;
  logic             fill_done;
  logic             wr_req;     // Store with line present, wants the bus
  logic             store_we;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  cache_array #(
    .LINE_WORDS (LINE_WORDS),
    .NUM_SETS   (NUM_SETS)
  ) array_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .addr        (addr),
    .fill_we     (fill_we),
    .fill_word   (port.rdata),
    .fill_offset (fill_cnt),
    .fill_done   (fill_done),
    .store_we    (store_we),
    .store_data  (wdata),
    .hit         (arr_hit),
    .rdata       (rdata)
  );

  // Refill side
  assign fill_we   = (state == ST_FILL) && port.valid;
  assign fill_done = fill_we && (&fill_cnt);

  // Write-through, the array is updated with the off-chip write
  assign wr_req   = (state == ST_IDLE) && en && wr && arr_hit;
  assign store_we = wr_req && port.grant;

  // Loads hit on lookup, stores once the write goes out
  assign hit = (state == ST_IDLE) && en && arr_hit && (!wr || port.grant);

  ////////////////////////////////////////
  // Request port
  ////////////////////////////////////////
  assign port.req   = (state == ST_FILL) || wr_req;
  assign port.wr    = wr_req;                       // Never during a fill
  assign port.addr  = (state == ST_FILL) ?
                      {addr[mem_bus_pkg::ADDR_W-1:OFF_W], fill_cnt} : addr;
  assign port.wdata = wdata;

  ////////////////////////////////////////
  // Miss FSM, write-allocate
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      fill_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: if (en && !arr_hit) begin
          state    <= ST_FILL;   // Load or store miss
          fill_cnt <= '0;
        end
        ST_FILL: if (port.valid) begin
          fill_cnt <= fill_cnt + 1'b1;
          if (fill_done) state <= ST_IDLE;  // A pending store retries as a hit
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Off-chip writes only ever carry a requester store
  a_wr_from_store: assert property (@(posedge clk) disable iff (!arst_n)
    (port.req && port.wr) |-> (en && wr));

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               mem_data_valid,  // Read word present
  input  mem_bus_pkg::word_t mem_data_in,
  mem_port_if.server         i_port,          // Instruction cache, high priority
  mem_port_if.server         d_port,          // Data cache
  output logic               mem_en,
  output mem_bus_pkg::addr_t mem_addr,
  output logic               mem_wr,
  output mem_bus_pkg::word_t mem_data_out
);

  localparam logic [1:0] OWN_NONE = 2'd0;
  localparam logic [1:0] OWN_I    = 2'd1;
  localparam logic [1:0] OWN_D    = 2'd2;

  logic [1:0] owner_q;     // Client in the middle of a line fill
  logic [1:0] owner_nxt;
  logic       i_holds;     // Locked owner still reading
  logic       d_holds;
  logic       grant_i;
  logic       grant_d;

  ////////////////////////////////////////
  // Grant, fixed priority plus fill lock
  ////////////////////////////////////////
  assign i_holds = (owner_q == OWN_I) && i_port.req && !i_port.wr;
  assign d_holds = (owner_q == OWN_D) && d_port.req && !d_port.wr;

  assign grant_i = i_holds || (!d_holds && i_port.req);
  assign grant_d = d_holds || (!i_holds && !i_port.req && d_port.req);

  // Reads lock, writes are single cycle and release at once
  assign owner_nxt = (grant_i && !i_port.wr) ? OWN_I :
                     (grant_d && !d_port.wr) ? OWN_D : OWN_NONE;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) owner_q <= OWN_NONE;
    else         owner_q <= owner_nxt;
  end

  assign i_port.grant = grant_i;
  assign d_port.grant = grant_d;

  // Off-chip bus follows the granted client
  assign mem_en       = grant_i || grant_d;
  assign mem_wr       = grant_i ? i_port.wr : (grant_d && d_port.wr);
  assign mem_addr     = grant_i ? i_port.addr : d_port.addr;
  assign mem_data_out = grant_i ? i_port.wdata : d_port.wdata;

  // Read return, steered to the owner only
  assign i_port.valid = grant_i && mem_data_valid;
  assign i_port.rdata = grant_i ? mem_data_in : '0;
  assign d_port.valid = grant_d && mem_data_valid;
  assign d_port.rdata = grant_d ? mem_data_in : '0;

  a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
    !(i_port.grant && d_port.grant));

  a_wr_needs_en: assert property (@(posedge clk) disable iff (!arst_n)
    mem_wr |-> mem_en);

endmodule

`default_nettype wire

// File: mem_front.sv
`timescale 1ns/100ps
`default_nettype none

module mem_front #(
  parameter int LINE_WORDS = cache_pkg::LINE_WORDS_DEF,
  parameter int NUM_SETS   = cache_pkg::NUM_SETS_DEF
) (
  input  logic               clk,
  input  logic               arst_n,
  // Fetch side
  input  mem_bus_pkg::addr_t if_addr,
  output mem_bus_pkg::word_t if_data,
  output logic               if_hit,         // Low stalls fetch
  // Load and store side
  input  logic               d_en,
  input  logic               d_wr,
  input  mem_bus_pkg::addr_t d_addr,
  input  mem_bus_pkg::word_t d_wdata,
  output mem_bus_pkg::word_t d_rdata,
  output logic               d_hit,          // Low stalls the memory stage
  // Off-chip memory
  input  logic               mem_data_valid,
  input  mem_bus_pkg::word_t mem_data_in,
  output logic               mem_en,
  output mem_bus_pkg::addr_t mem_addr,
  output logic               mem_wr,
  output mem_bus_pkg::word_t mem_data_out
);

  mem_port_if i_port ();   // icache to arbiter
  mem_port_if d_port ();   // dcache to arbiter

  icache #(.LINE_WORDS(LINE_WORDS), .NUM_SETS(NUM_SETS)) icache_i (
    .clk    (clk),
    .arst_n (arst_n),
    .addr   (if_addr),
    .data   (if_data),
    .hit    (if_hit),
    .port   (i_port.client)
  );

  dcache #(.LINE_WORDS(LINE_WORDS), .NUM_SETS(NUM_SETS)) dcache_i (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (d_en),
    .wr     (d_wr),
    .addr   (d_addr),
    .wdata  (d_wdata),
    .rdata  (d_rdata),
    .hit    (d_hit),
    .port   (d_port.client)
  );

  mem_arbiter arbiter_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .mem_data_valid (mem_data_valid),
    .mem_data_in    (mem_data_in),
    .i_port         (i_port.server),
    .d_port         (d_port.server),
    .mem_en         (mem_en),
    .mem_addr       (mem_addr),
    .mem_wr         (mem_wr),
    .mem_data_out   (mem_data_out)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 5,
  parameter int DRIVE_DLY    = 5    // Reset release lands just after an edge
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;                          // Held for the first cycles
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DLY) arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_mem_front.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_front;

  localparam int LINE_WORDS = cache_pkg::LINE_WORDS_DEF;
  localparam int NUM_SETS   = cache_pkg::NUM_SETS_DEF;
  localparam int OFF_W      = $clog2(LINE_WORDS);
  localparam int IDX_W      = $clog2(NUM_SETS);
  localparam int TAG_W      = mem_bus_pkg::ADDR_W - OFF_W - IDX_W;
  localparam int DRIVE_DLY  = 5;                 // ns after the rising edge
  localparam int TIMEOUT    = 200;               // Cycles per wait
  localparam int EVICT_N    = 4;
  localparam int LAT_N      = 64;                // Latency table length

  localparam mem_bus_pkg::addr_t I_ADDR  = 16'h0122;  // First fetch in set 8
  localparam mem_bus_pkg::addr_t D_ADDR  = 16'h3455;  // First load in set 21
  localparam mem_bus_pkg::addr_t W_MISS  = 16'h7a0b;  // Store to an absent line in set 2
  localparam mem_bus_pkg::addr_t I2_ADDR = 16'h0c31;  // Priority pair
  localparam mem_bus_pkg::addr_t D2_ADDR = 16'h5167;
  localparam mem_bus_pkg::addr_t D3_ADDR = 16'h61c9;  // Locked data fill in set 18
  localparam mem_bus_pkg::addr_t I3_ADDR = 16'h2a5e;  // Fetch miss in set 23 during that fill

  logic clk, arst_n;
  mem_bus_pkg::addr_t if_addr, d_addr, mem_addr;
  mem_bus_pkg::word_t if_data, d_wdata, d_rdata, mem_data_in, mem_data_out;
  logic if_hit, d_en, d_wr, d_hit, mem_data_valid, mem_en, mem_wr;

  int err_count;
  int check_count;

  // Off-chip memory model state owned by the model process
  mem_bus_pkg::word_t mem_words [mem_bus_pkg::addr_t];  // Written words only
  mem_bus_pkg::addr_t rd_log [$];                        // Read addresses in issue order
  mem_bus_pkg::addr_t rd_addr, wr_addr_seen;
  mem_bus_pkg::word_t wr_data_seen;
  logic busy;
  int   rd_wait, wr_count, proto_err;
  int   lat_seq [LAT_N];                                 // Read latency by read number

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(5), .DRIVE_DLY(DRIVE_DLY)) clock_gen_i (
    .clk    (clk),
    .arst_n (arst_n)
  );

  mem_front #(.LINE_WORDS(LINE_WORDS), .NUM_SETS(NUM_SETS)) dut_i (
    .clk (clk), .arst_n (arst_n),
    .if_addr (if_addr), .if_data (if_data), .if_hit (if_hit),
    .d_en (d_en), .d_wr (d_wr), .d_addr (d_addr), .d_wdata (d_wdata),
    .d_rdata (d_rdata), .d_hit (d_hit),
    .mem_data_valid (mem_data_valid), .mem_data_in (mem_data_in),
    .mem_en (mem_en), .mem_addr (mem_addr), .mem_wr (mem_wr), .mem_data_out (mem_data_out)
  );

  // Unwritten words read as a pattern of the whole address
  function automatic mem_bus_pkg::word_t model_word(input mem_bus_pkg::addr_t a);
    if (mem_words.exists(a)) return mem_words[a];
    return a ^ 16'h5a5a;
  endfunction

  function automatic mem_bus_pkg::addr_t line_base(input mem_bus_pkg::addr_t a);
    return a & ~mem_bus_pkg::addr_t'(LINE_WORDS - 1);
  endfunction

  function automatic mem_bus_pkg::addr_t make_addr(input int tag, input int idx, input int off);
    return mem_bus_pkg::addr_t'((tag << (OFF_W + IDX_W)) | (idx << OFF_W) | off);
  endfunction

  // Random read latencies drawn up front from the seeded stream
  task automatic draw_latencies;
    int i;
    for (i = 0; i < LAT_N; i++) begin
      lat_seq[i] = 1 + ($urandom % 4);               // 1 to 4 cycles
    end
  endtask

  ////////////////////////////////////////
  // Behavioral off-chip memory
  ////////////////////////////////////////
  initial begin
    mem_data_valid = 1'b0;
    mem_data_in    = '0;
    busy           = 1'b0;
    wr_count       = 0;
    proto_err      = 0;
    forever begin
      @(negedge clk);                                 // Requests sampled mid-cycle
      if (mem_en && mem_wr) begin
        mem_words[mem_addr] = mem_data_out;           // Accepted in this cycle
        wr_count++;
        wr_addr_seen = mem_addr;
        wr_data_seen = mem_data_out;
      end else if (mem_en && !mem_data_valid) begin
        if (!busy) begin
          busy    = 1'b1;
          rd_addr = mem_addr;
          rd_wait = lat_seq[rd_log.size() % LAT_N];
          rd_log.push_back(mem_addr);
        end else begin
          assert (mem_addr === rd_addr) else begin
            $display("mem_addr moved away from %h while its read was outstanding", rd_addr);
            proto_err++;
          end
        end
      end
      @(posedge clk);
      #(DRIVE_DLY);
      if (mem_data_valid) begin
        mem_data_valid = 1'b0;                        // One cycle strobe
        busy           = 1'b0;
      end else if (busy) begin
        rd_wait--;
        if (rd_wait == 0) begin
          mem_data_valid = 1'b1;
          mem_data_in    = model_word(rd_addr);
        end
      end
    end
  end

  ////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("Error: %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic finish_run;
    err_count = err_count + proto_err;
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    $display("Timed out waiting for %s", what);
    err_count++;
    finish_run();
  endtask

  task automatic step;
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic wait_reset_release;
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (arst_n) return;
    end
    timeout_abort("reset release");
  endtask

  // Waits for either hit or both at mid-cycle
  task automatic wait_until_hit(input logic want_i, input logic want_d, input string what);
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if ((!want_i || if_hit) && (!want_d || d_hit)) return;
    end
    timeout_abort(what);
  endtask

  // First read of a line fill seen on the bus
  task automatic wait_fill_start(input mem_bus_pkg::addr_t a);
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (mem_en && !mem_wr && mem_addr === line_base(a)) return;
    end
    timeout_abort("the data line fill to reach the bus");
  endtask

  task automatic check_line_reads(input int start, input mem_bus_pkg::addr_t a);
    int i;
    for (i = 0; i < LINE_WORDS; i++) begin
      if (start + i < rd_log.size()) check_value("mem_addr", rd_log[start + i], line_base(a) + i);
    end
  endtask

  ////////////////////////////////////////
  // Data side access helpers
  ////////////////////////////////////////
  task automatic data_read_miss(input mem_bus_pkg::addr_t a);
    int start;
    start = rd_log.size();
    step();
    d_en   = 1'b1;
    d_wr   = 1'b0;
    d_addr = a;
    wait_until_hit(1'b0, 1'b1, "d_hit after a load miss");
    check_value("read count", rd_log.size() - start, LINE_WORDS);
    check_line_reads(start, a);
    check_value("d_rdata", d_rdata, model_word(a));
    step();
    d_en = 1'b0;
  endtask

  task automatic data_read_hit(input mem_bus_pkg::addr_t a, input mem_bus_pkg::word_t exp);
    int start;
    start = rd_log.size();
    step();
    d_en   = 1'b1;
    d_wr   = 1'b0;
    d_addr = a;
    @(negedge clk);                                   // Hit is combinational
    check_value("d_hit", d_hit, 1);
    check_value("d_rdata", d_rdata, exp);
    check_value("read count", rd_log.size() - start, 0);
    step();
    d_en = 1'b0;
  endtask

  task automatic data_write(input mem_bus_pkg::addr_t a, input mem_bus_pkg::word_t wd,
                            input logic miss);
    int rstart, wstart;
    rstart = rd_log.size();
    wstart = wr_count;
    step();
    d_en    = 1'b1;
    d_wr    = 1'b1;
    d_addr  = a;
    d_wdata = wd;
    wait_until_hit(1'b0, 1'b1, "d_hit on a store");
    step();
    d_en = 1'b0;
    d_wr = 1'b0;
    @(negedge clk);                                   // Write now logged by the model
    check_value("read count", rd_log.size() - rstart, miss ? LINE_WORDS : 0);
    if (miss) check_line_reads(rstart, a);
    check_value("write count", wr_count - wstart, 1);
    check_value("mem_addr", wr_addr_seen, a);
    check_value("mem_data_out", wr_data_seen, wd);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic test_reset_fetch;
    int start;
    @(negedge clk);
    check_value("mem_en", mem_en, 0);
    check_value("mem_wr", mem_wr, 0);
    wait_reset_release();
    check_value("mem_en", mem_en, 0);                 // FSMs still idle
    check_value("mem_wr", mem_wr, 0);
    start = rd_log.size();
    wait_until_hit(1'b1, 1'b0, "if_hit after the first fetch");
    check_value("read count", rd_log.size() - start, LINE_WORDS);
    check_line_reads(start, I_ADDR);
    check_value("if_data", if_data, model_word(I_ADDR));
  endtask

  task automatic test_fetch_hits;
    int start, off;
    start = rd_log.size();
    for (off = 0; off < LINE_WORDS; off++) begin
      step();
      if_addr = line_base(I_ADDR) + off;
      @(negedge clk);
      check_value("if_hit", if_hit, 1);
      check_value("if_data", if_data, model_word(if_addr));
    end
    check_value("read count", rd_log.size() - start, 0);
  endtask

  task automatic test_data_read;
    data_read_miss(D_ADDR);
    data_read_hit(D_ADDR ^ 16'h1, model_word(D_ADDR ^ 16'h1));  // Same line
  endtask

  task automatic test_write_through;
    mem_bus_pkg::word_t wd;
    wd = mem_bus_pkg::word_t'($urandom);
    data_write(D_ADDR, wd, 1'b0);                     // Line present
    data_read_hit(D_ADDR, wd);
    wd = mem_bus_pkg::word_t'($urandom);
    data_write(W_MISS, wd, 1'b1);                     // Allocate and then write
    data_read_hit(W_MISS, wd);
    data_read_hit(W_MISS ^ 16'h1, model_word(W_MISS ^ 16'h1));
  endtask

  task automatic test_priority;
    int start;
    start = rd_log.size();
    step();
    if_addr = I2_ADDR;                                // Both miss in one cycle
    d_en    = 1'b1;
    d_wr    = 1'b0;
    d_addr  = D2_ADDR;
    wait_until_hit(1'b1, 1'b1, "if_hit and d_hit after two misses");
    check_value("read count", rd_log.size() - start, 2 * LINE_WORDS);
    check_line_reads(start, I2_ADDR);                 // Fetch line goes first
    check_line_reads(start + LINE_WORDS, D2_ADDR);
    check_value("if_data", if_data, model_word(I2_ADDR));
    check_value("d_rdata", d_rdata, model_word(D2_ADDR));
    step();
    d_en = 1'b0;
  endtask

  // A fetch miss that arrives during a data fill waits for the whole line
  task automatic test_fill_lock;
    int start;
    start = rd_log.size();
    step();
    d_en   = 1'b1;
    d_wr   = 1'b0;
    d_addr = D3_ADDR;
    wait_fill_start(D3_ADDR);
    step();
    if_addr = I3_ADDR;                                // Fetch misses mid-fill
    wait_until_hit(1'b1, 1'b1, "if_hit and d_hit after a locked fill");
    check_value("read count", rd_log.size() - start, 2 * LINE_WORDS);
    check_line_reads(start, D3_ADDR);                 // Data line completes first
    check_line_reads(start + LINE_WORDS, I3_ADDR);
    check_value("d_rdata", d_rdata, model_word(D3_ADDR));
    check_value("if_data", if_data, model_word(I3_ADDR));
    step();
    d_en = 1'b0;
  endtask

  task automatic test_eviction;
    int tag0, k;
    mem_bus_pkg::addr_t first;
    tag0  = $urandom % (1 << TAG_W);
    first = make_addr(tag0, NUM_SETS - 2, $urandom % LINE_WORDS);
    for (k = 0; k < EVICT_N; k++) begin
      data_read_miss(make_addr(tag0 ^ k, NUM_SETS - 2, $urandom % LINE_WORDS));
    end
    data_read_miss(first);                            // Evicted long ago
  endtask

  initial begin
    void'($urandom(32'hcb48c651));
    draw_latencies();
    err_count   = 0;
    check_count = 0;
    if_addr     = I_ADDR;                             // Fetch starts right out of reset
    d_en        = 1'b0;
    d_wr        = 1'b0;
    d_addr      = '0;
    d_wdata     = '0;
    test_reset_fetch();
    test_fetch_hits();
    test_data_read();
    test_write_through();
    test_priority();
    test_fill_lock();
    test_eviction();
    finish_run();
  end

endmodule

`default_nettype wire

// File: compile.f
mem_bus_pkg.sv
cache_pkg.sv
mem_port_if.sv
cache_array.sv
icache.sv
dcache.sv
mem_arbiter.sv
mem_front.sv
tb_clock_gen.sv
tb_mem_front.sv
